// ==== pic_8259.f ====
pic_pkg.sv
pic_cmd_decoder.sv
pic_priority_resolver.sv
pic_ack_sequencer.sv
pic_8259_top.sv
pic_checker.sv
tb_pic.sv

// ==== pic_8259_top.sv ====
`timescale 1ns/1ps

module pic_8259_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic               paddr,
    input  pic_pkg::pic_data_t pwdata,
    input  pic_pkg::irq_vec_t  ir,
    input  logic               inta_n,
    output pic_pkg::pic_data_t prdata,
    output logic               intr,      // INT pin to the CPU INTR input
    output pic_pkg::pic_data_t data_out,
    output logic               data_oe
);
    import pic_pkg::*;

    // Decoder to resolver
    irq_vec_t     imr;
    logic         ltim;
    logic         aeoi;
    logic         icw1_write;
    logic         eoi_valid;
    logic         eoi_specific;
    irq_level_t   eoi_level;
    irq_vec_t     irr;        // Back to decoder for read-back
    irq_vec_t     isr;
    // Decoder and resolver to sequencer
    vector_base_t vector_base;
    irq_level_t   ack_level;
    logic         ack_latch;
    logic         ack_done;

    pic_cmd_decoder u_cmd_decoder (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .irr, .isr, .imr, .ltim, .aeoi, .icw1_write,
        .eoi_valid, .eoi_specific, .eoi_level, .vector_base
    );

    pic_priority_resolver u_priority_resolver (
        .clk, .reset, .ir, .imr, .ltim, .aeoi, .icw1_write,
        .eoi_valid, .eoi_specific, .eoi_level, .ack_latch, .ack_done,
        .irr, .isr, .ack_level, .intr
    );

    pic_ack_sequencer u_ack_sequencer (
        .clk, .reset, .inta_n, .icw1_write, .vector_base, .ack_level,
        .ack_latch, .ack_done, .data_oe, .data_out
    );

endmodule

// ==== pic_ack_sequencer.sv ====
`timescale 1ns/1ps

module pic_ack_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inta_n,
    input  logic                  icw1_write,
    input  pic_pkg::vector_base_t vector_base,
    input  pic_pkg::irq_level_t   ack_level,
    output logic                  ack_latch,
    output logic                  ack_done,
    output logic                  data_oe,
    output pic_pkg::pic_data_t    data_out
);
    import pic_pkg::*;

    ack_state_e ack_state;
    logic       inta_q;     // Last sampled INTA
    logic       inta_fall;
    logic       inta_rise;

    assign inta_fall = inta_q & ~inta_n;
    assign inta_rise = ~inta_q & inta_n;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_state <= ACK_IDLE;
            inta_q    <= 1'b1;   // INTA idles high
            ack_latch <= 1'b0;
            ack_done  <= 1'b0;
        end else begin
            inta_q    <= inta_n;
            ack_latch <= 1'b0;
            ack_done  <= 1'b0;
            if (icw1_write) begin
                ack_state <= ACK_IDLE; // Abandon any half-done acknowledge
            end else begin
                case (ack_state)
                    ACK_IDLE: begin
                        if (inta_fall) begin
                            ack_state <= ACK_FIRST;
                            ack_latch <= 1'b1; // Freeze winner into ISR
                        end
                    end
                    ACK_FIRST: if (inta_rise) ack_state <= ACK_GAP;
                    ACK_GAP:   if (inta_fall) ack_state <= ACK_SECOND;
                    ACK_SECOND: begin
                        if (inta_rise) begin
                            ack_state <= ACK_IDLE;
                            ack_done  <= 1'b1;
                        end
                    end
                    default: ack_state <= ACK_IDLE;
                endcase
            end
        end
    end

    // Vector byte only in the second pulse, bus idle otherwise
    assign data_oe  = (ack_state == ACK_SECOND);
    assign data_out = data_oe ? {vector_base, ack_level} : '0;

endmodule

// ==== pic_checker.sv ====
`timescale 1ns/1ps

module pic_checker (
    input logic                  clk,
    input logic                  reset,
    input pic_pkg::ack_state_e   ack_state,
    input logic                  ack_latch,
    input logic                  ack_done,
    input logic                  data_oe,
    input pic_pkg::pic_data_t    data_out
);
    import pic_pkg::*;

    // Vector byte held steady for the whole second pulse
    vector_steady: assert property (@(posedge clk) disable iff (reset)
        (ack_state == ACK_SECOND && $past(ack_state) == ACK_SECOND) |-> $stable(data_out))
        else $error("vector byte changed during the second INTA pulse");

    latch_done_apart: assert property (@(posedge clk) disable iff (reset)
        !(ack_latch && ack_done))
        else $error("ack_latch and ack_done together");

    // Outputs quiet while reset holds
    quiet_in_reset: assert property (@(posedge clk)
        reset |=> (!ack_latch && !ack_done && !data_oe && data_out == '0))
        else $error("sequencer outputs active during reset");

endmodule

bind pic_ack_sequencer pic_checker u_checker (.*);

// ==== pic_cmd_decoder.sv ====
`timescale 1ns/1ps

module pic_cmd_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic                  paddr,
    input  pic_pkg::pic_data_t    pwdata,
    output pic_pkg::pic_data_t    prdata,
    input  pic_pkg::irq_vec_t     irr,
    input  pic_pkg::irq_vec_t     isr,
    output pic_pkg::irq_vec_t     imr,
    output logic                  ltim,
    output logic                  aeoi,
    output logic                  icw1_write,
    output logic                  eoi_valid,
    output logic                  eoi_specific,
    output pic_pkg::irq_level_t   eoi_level,
    output pic_pkg::vector_base_t vector_base
);
    import pic_pkg::*;

    init_state_e init_state;
    logic        ic4;       // ICW4 follows ICW2
    logic        read_isr;  // OCW3 RIS, ISR when set
    logic        wr_access; // Write lands at end of access phase
    logic        rd_setup;  // Read data captured in setup phase
    logic        cmd_wr;
    logic        data_wr;
    logic        icw1_hit;
    logic        ocw2_hit;
    logic        ocw3_hit;

    assign wr_access = psel & penable & pwrite;
    assign rd_setup  = psel & ~penable & ~pwrite;
    assign cmd_wr    = wr_access & (paddr == ADDR_CMD);
    assign data_wr   = wr_access & (paddr == ADDR_DATA);

    // Command port split on D4 and D3
    assign icw1_hit = cmd_wr & pwdata[4];
    assign ocw2_hit = cmd_wr & ~pwdata[4] & ~pwdata[3];
    assign ocw3_hit = cmd_wr & ~pwdata[4] & pwdata[3];

    always_ff @(posedge clk) begin
        if (reset) begin
            init_state   <= INIT_READY;
            ic4          <= 1'b0;
            read_isr     <= 1'b0;
            imr          <= '1;   // Everything masked
            ltim         <= 1'b0;
            aeoi         <= 1'b0;
            vector_base  <= '0;
            icw1_write   <= 1'b0;
            eoi_valid    <= 1'b0;
            eoi_specific <= 1'b0;
            eoi_level    <= '0;
            prdata       <= '0;
        end else begin
            icw1_write <= icw1_hit; // Resolver and sequencer restart one cycle later
            eoi_valid  <= 1'b0;
            if (icw1_hit) begin
                init_state <= INIT_ICW2;
                imr        <= '1;
                aeoi       <= 1'b0;
                read_isr   <= 1'b0;     // Back to IRR read-back
                ltim       <= pwdata[3];
                ic4        <= pwdata[0]; // SNGL in D1 not used, always single
            end else if (data_wr) begin
                case (init_state)
                    INIT_ICW2: begin
                        vector_base <= pwdata[7:3];
                        init_state  <= ic4 ? INIT_ICW4 : INIT_READY;
                    end
                    INIT_ICW4: begin
                        aeoi       <= pwdata[1]; // uPM in D0 ignored, 8086 only
                        init_state <= INIT_READY;
                    end
                    default: imr <= pwdata; // OCW1
                endcase
            end else if (ocw2_hit) begin
                // 001 non-specific, 011 specific, rest ignored
                eoi_valid    <= (pwdata[7:5] == 3'b001) || (pwdata[7:5] == 3'b011);
                eoi_specific <= pwdata[6];
                eoi_level    <= pwdata[2:0];
            end else if (ocw3_hit && pwdata[1]) begin
                read_isr <= pwdata[0]; // RR set, RIS picks register
            end

            // Registered read mux, valid through the access phase
            if (rd_setup)
                prdata <= (paddr == ADDR_DATA) ? imr : (read_isr ? isr : irr);
        end
    end

endmodule

// ==== pic_pkg.sv ====
package pic_pkg;

    // Request lines, fixed by the 8259 encoding
    parameter int NUM_IRQ = 8;

    typedef logic [NUM_IRQ-1:0] irq_vec_t;    // One bit per level, IR0 in bit 0
    typedef logic [2:0]         irq_level_t;  // Level number 0 to 7
    typedef logic [7:0]         pic_data_t;   // APB data and INTA vector byte
    typedef logic [4:0]         vector_base_t; // T7-T3 from ICW2

    // Level returned when the first INTA finds nothing to serve
    parameter irq_level_t SPURIOUS_LEVEL = 3'd7;

    // A0 decode
    parameter logic ADDR_CMD  = 1'b0;
    parameter logic ADDR_DATA = 1'b1;

    // ICW sequence
    typedef enum logic [1:0] {
        INIT_READY,  // OCWs accepted
        INIT_ICW2,   // Waiting for vector base
        INIT_ICW4    // Waiting for mode word
    } init_state_e;

    // Two-pulse 8086 acknowledge
    typedef enum logic [1:0] {
        ACK_IDLE,
        ACK_FIRST,   // First INTA pulse low
        ACK_GAP,     // Between the two pulses
        ACK_SECOND   // Second pulse low, vector on the bus
    } ack_state_e;

    // Lowest set bit wins, IR0 highest priority
    // Empty vector gives level 7
    function automatic irq_level_t lowest_set_level(irq_vec_t vec);
        irq_level_t level;
        level = SPURIOUS_LEVEL;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (vec[i])
                level = irq_level_t'(i); // Later hit has higher priority
        end
        return level;
    endfunction

endpackage

// ==== pic_priority_resolver.sv ====
`timescale 1ns/1ps

module pic_priority_resolver (
    input  logic                clk,
    input  logic                reset,
    input  pic_pkg::irq_vec_t   ir,
    input  pic_pkg::irq_vec_t   imr,
    input  logic                ltim,
    input  logic                aeoi,
    input  logic                icw1_write,
    input  logic                eoi_valid,
    input  logic                eoi_specific,
    input  pic_pkg::irq_level_t eoi_level,
    input  logic                ack_latch,
    input  logic                ack_done,
    output pic_pkg::irq_vec_t   irr,
    output pic_pkg::irq_vec_t   isr,
    output pic_pkg::irq_level_t ack_level,
    output logic                intr
);
    import pic_pkg::*;

    irq_vec_t   ir_q;        // Previous sample for edge detect
    irq_vec_t   ir_rise;
    irq_vec_t   pending;     // Unmasked requests
    irq_level_t win_level;
    irq_level_t isr_level;   // Level currently in service
    logic       win_valid;   // Winner beats everything in service
    logic       ack_hit;     // Acknowledge served a real level
    irq_vec_t   win_mask;
    irq_vec_t   irr_capture;
    irq_vec_t   isr_set;
    irq_vec_t   isr_clr;

    assign ir_rise     = ir & ~ir_q;
    assign irr_capture = ltim ? ir : (irr | ir_rise); // Level mode tracks ir
    assign pending     = irr & ~imr;
    assign win_level   = lowest_set_level(pending);
    assign isr_level   = lowest_set_level(isr);
    assign win_mask    = irq_vec_t'(1) << win_level;

    // Fully nested, only a strictly higher level gets through
    assign win_valid = (pending != '0) && ((isr == '0) || (win_level < isr_level));

    always_comb begin
        isr_set = '0;
        isr_clr = '0;
        if (ack_latch && win_valid)
            isr_set = win_mask;
        if (eoi_valid)
            isr_clr = eoi_specific ? (irq_vec_t'(1) << eoi_level) : (irq_vec_t'(1) << isr_level);
        if (ack_done && aeoi && ack_hit)
            isr_clr = isr_clr | (irq_vec_t'(1) << ack_level); // Auto EOI at end of INTA
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ir_q      <= '0;
            irr       <= '0;
            isr       <= '0;
            ack_level <= '0;
            ack_hit   <= 1'b0;
            intr      <= 1'b0;
        end else begin
            ir_q <= ir;
            if (icw1_write) begin
                irr     <= '0;
                isr     <= '0;
                ack_hit <= 1'b0;
                intr    <= 1'b0;
            end else begin
                // Winner leaves IRR as it enters ISR
                irr  <= irr_capture & ~isr_set;
                isr  <= (isr & ~isr_clr) | isr_set;
                intr <= ack_latch ? 1'b0 : win_valid;
                if (ack_latch) begin
                    ack_level <= win_valid ? win_level : SPURIOUS_LEVEL;
                    ack_hit   <= win_valid;
                end
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the 8259 core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pic -Mdir obj_dir -f pic_8259.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_pic > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

// ==== tb_pic.sv ====
`timescale 1ns/1ps

module tb_pic;
    import pic_pkg::*;

    logic      clk;
    logic      reset;
    logic      psel;
    logic      penable;
    logic      pwrite;
    logic      paddr;
    pic_data_t pwdata;
    irq_vec_t  ir;
    logic      inta_n;
    pic_data_t prdata;
    logic      intr;
    pic_data_t data_out;
    logic      data_oe;

    integer       seed = 32'h904e8f08;
    integer       errors = 0;
    integer       tests = 0;
    integer       failed_tests = 0;
    // Reference model state
    irq_vec_t     m_imr;
    irq_vec_t     m_irr;
    irq_vec_t     m_isr;
    logic         m_aeoi;
    vector_base_t m_base;

    pic_8259_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Highest priority is the lowest set bit, 7 when empty
    function automatic irq_level_t expected_level(irq_vec_t v);
        for (int i = 0; i < 8; i++)
            if (v[i]) return irq_level_t'(i);
        return 3'd7;
    endfunction

    task automatic check_byte(input pic_data_t got, input pic_data_t exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %02h expected %02h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_irq_vec(input irq_vec_t got, input irq_vec_t exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %08b expected %08b", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_int(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s int is %b expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic apb_write(input logic addr, input pic_data_t data);
        @(posedge clk);
        psel    <= 1'b1;    // Setup phase
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);     // Write lands here
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic addr, output pic_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;      // Mid access phase
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Two INTA pulses, each phase held 2 to 5 cycles, vector sampled in the second
    task automatic inta_cycle(output pic_data_t vec, output logic oe);
        int n;
        @(posedge clk);
        inta_n <= 1'b0;
        n = 2 + ($unsigned($random(seed)) % 4);
        repeat (n) @(posedge clk);
        inta_n <= 1'b1;
        n = 2 + ($unsigned($random(seed)) % 4);
        repeat (n) @(posedge clk);
        inta_n <= 1'b0;
        n = 2 + ($unsigned($random(seed)) % 4);
        repeat (n - 1) @(posedge clk);
        @(negedge clk);
        vec = data_out;
        oe  = data_oe;
        @(posedge clk);
        inta_n <= 1'b1;
        repeat (3) @(posedge clk); // Let ack_done and AEOI settle
    endtask

    task automatic wait_int();
        for (int i = 0; i < 50 && !intr; i++)
            @(negedge clk);
        if (!intr) begin
            $display("timeout at %0t: int never rose", $time);
            errors++;
        end
    endtask

    task automatic pulse_ir(input irq_vec_t v);
        @(posedge clk);
        ir <= v;
        @(posedge clk);
        ir <= '0;
        m_irr = m_irr | v;  // Edge capture
    endtask

    task automatic init_pic(input logic ltim, input logic ic4, input logic aeoi, input irq_vec_t mask);
        m_base = vector_base_t'($random(seed));
        apb_write(ADDR_CMD, {3'b000, 1'b1, ltim, 2'b00, ic4});
        apb_write(ADDR_DATA, {m_base, 3'b000});
        if (ic4)
            apb_write(ADDR_DATA, {6'b0, aeoi, 1'b0});
        apb_write(ADDR_DATA, mask);
        m_imr  = mask;
        m_irr  = '0;
        m_isr  = '0;
        m_aeoi = ic4 & aeoi; // ICW1 clears AEOI, only ICW4 sets it
    endtask

    // Acknowledge and compare the vector against the model winner
    task automatic serve(input string msg);
        pic_data_t  vec;
        logic       oe;
        irq_level_t lvl;
        logic       hit;
        lvl = expected_level(m_irr & ~m_imr);
        hit = ((m_irr & ~m_imr) != '0) &&
              ((m_isr == '0) || (lvl < expected_level(m_isr)));
        if (!hit)
            lvl = 3'd7;     // Nothing beats the level in service, spurious
        inta_cycle(vec, oe);
        if (oe !== 1'b1) begin
            $display("mismatch at %0t: data_oe low during the second INTA pulse", $time);
            errors++;
        end
        check_byte(vec, {m_base, lvl}, msg);
        if (hit) begin
            m_irr[lvl] = 1'b0;
            m_isr[lvl] = 1'b1;
            if (m_aeoi)
                m_isr[lvl] = 1'b0; // Cleared again at the end of INTA
        end
    endtask

    task automatic end_test(input string name, input integer err_before);
        tests++;
        if (errors != err_before)
            failed_tests++;
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "errors");
    endtask

    initial begin
        pic_data_t  rd;
        irq_vec_t   v;
        irq_level_t a;
        irq_level_t b;
        integer     e;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 1'b0;
        pwdata = '0;
        ir = '0;
        inta_n = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        e = errors; // Init and read-back
        init_pic(1'b0, 1'b1, 1'b0, irq_vec_t'($random(seed)));
        apb_read(ADDR_DATA, rd);
        check_irq_vec(rd, m_imr, "IMR read-back");
        apb_read(ADDR_CMD, rd);
        check_irq_vec(rd, '0, "IRR after init");
        apb_write(ADDR_CMD, 8'h0B);
        apb_read(ADDR_CMD, rd);
        check_irq_vec(rd, '0, "ISR after init");
        end_test("init", e);

        e = errors; // Edge mode priority and masking
        for (int k = 0; k < 4; k++) begin
            v = irq_vec_t'($random(seed)) | (irq_vec_t'(1) << ($unsigned($random(seed)) % 8));
            init_pic(1'b0, 1'b0, 1'b0, irq_vec_t'($random(seed)) & ~(v & -v));
            pulse_ir(v);
            wait_int();
            apb_read(ADDR_CMD, rd);
            check_irq_vec(rd, m_irr, "IRR before ack");
            serve("edge vector");
            apb_read(ADDR_CMD, rd);
            check_irq_vec(rd, m_irr, "IRR after ack");
            apb_write(ADDR_CMD, 8'h0B);
            apb_read(ADDR_CMD, rd);
            check_irq_vec(rd, m_isr, "ISR after ack");
            @(negedge clk);
            check_int(intr, 1'b0, "lower levels blocked");
        end
        end_test("edge_priority", e);

        e = errors; // Fully nested blocking
        init_pic(1'b0, 1'b0, 1'b0, '0);
        a = irq_level_t'(1 + ($unsigned($random(seed)) % 6));
        pulse_ir(irq_vec_t'(1) << a);
        wait_int();
        serve("nested first");
        b = irq_level_t'(a + ($unsigned($random(seed)) % (8 - a)));
        pulse_ir(irq_vec_t'(1) << b);
        repeat (6) @(negedge clk);
        check_int(intr, 1'b0, "request at or below service level");
        b = irq_level_t'($unsigned($random(seed)) % a);
        pulse_ir(irq_vec_t'(1) << b);
        wait_int();
        apb_read(ADDR_CMD, rd);
        check_irq_vec(rd, m_irr, "IRR with nested requests");
        end_test("nested", e);

        e = errors; // Non-specific then specific EOI
        init_pic(1'b0, 1'b0, 1'b0, '0);
        a = irq_level_t'(4 + ($unsigned($random(seed)) % 4));
        b = irq_level_t'($unsigned($random(seed)) % 4);
        pulse_ir(irq_vec_t'(1) << a);
        wait_int();
        serve("eoi low priority");
        pulse_ir(irq_vec_t'(1) << b);
        wait_int();
        serve("eoi high priority");
        apb_write(ADDR_CMD, 8'h0B);
        apb_read(ADDR_CMD, rd);
        check_irq_vec(rd, m_isr, "ISR with two in service");
        apb_write(ADDR_CMD, 8'h20);
        m_isr[b] = 1'b0;    // Lowest bit goes first
        apb_read(ADDR_CMD, rd);
        check_irq_vec(rd, m_isr, "ISR after non-specific EOI");
        apb_write(ADDR_CMD, {5'b01100, a});
        m_isr[a] = 1'b0;
        apb_read(ADDR_CMD, rd);
        check_irq_vec(rd, m_isr, "ISR after specific EOI");
        end_test("eoi", e);

        e = errors; // Automatic EOI
        init_pic(1'b0, 1'b1, 1'b1, '0);
        apb_write(ADDR_CMD, 8'h0B);
        for (int k = 0; k < 3; k++) begin
            pulse_ir(irq_vec_t'($random(seed)) | 8'h80);
            wait_int();
            serve("aeoi vector");
            apb_read(ADDR_CMD, rd);
            check_irq_vec(rd, m_isr, "ISR after auto EOI");
        end
        end_test("aeoi", e);

        e = errors; // Level mode, then spurious acknowledge
        init_pic(1'b1, 1'b0, 1'b0, '0);
        v = irq_vec_t'($random(seed)) | 8'h01;
        @(posedge clk);
        ir <= v;
        repeat (2) @(posedge clk);
        apb_read(ADDR_CMD, rd);
        check_irq_vec(rd, v, "IRR follows ir");
        wait_int();
        @(posedge clk);
        ir <= '0;
        m_irr = '0;
        repeat (3) @(posedge clk);
        apb_read(ADDR_CMD, rd);
        check_irq_vec(rd, '0, "IRR after ir drop");
        serve("spurious vector");
        apb_write(ADDR_CMD, 8'h0B);
        apb_read(ADDR_CMD, rd);
        check_irq_vec(rd, m_isr, "ISR after spurious ack");
        end_test("level_spurious", e);

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
